/* src/frame_buf_cfg.svh */
// frame buffer write side configuration macros: widths, burst size, address layout, pointer reset
`ifndef FRAME_BUF_CFG_SVH
`define FRAME_BUF_CFG_SVH

// ----------------------------------------
// data path
// ----------------------------------------
// one pixel word as stored in the memory controller write FIFO
`define FB_DATA_WIDTH		32

// ----------------------------------------
// frame pointer and row counter
// ----------------------------------------
// 2 bits give up to 4 frames
`define FB_PTR_WIDTH		2
// row counter covers a whole 1 Gb part at single-frame depth
`define FB_ROW_WIDTH		19
// write starts one frame ahead of the read
`define FB_PTR_RESET		1

// ----------------------------------------
// memory controller command
// ----------------------------------------
// largest run of words under one write command
`define FB_BURST_WORDS		64
// burst length field, words minus one
`define FB_BL_WIDTH			6
// full byte address seen by the controller port
`define FB_BYTE_ADDR_WIDTH	30
// one burst is 256 bytes, so these low bits stay zero
`define FB_BYTE_LSB			8

`endif

/* src/frame_buf_pkg.sv */
// frame buffer types: write state, frame pointer, frame depth, row address, word count
`include "frame_buf_cfg.svh"

package frame_buf_pkg;

	// ----------------------------------------
	// write sequencer states
	// ----------------------------------------
	typedef enum logic [1:0] {
		S_IDLE	= 2'd0,
		S_REQ	= 2'd1,
		S_WR	= 2'd2,
		S_CMD	= 2'd3
	} wr_state_t;

	// frame index inside the buffer
	typedef logic [`FB_PTR_WIDTH-1:0] frame_ptr_t;

	// number of frames minus one, 0 means single frame
	typedef logic [`FB_PTR_WIDTH-1:0] frame_depth_t;

	// burst row inside one frame
	typedef logic [`FB_ROW_WIDTH-1:0] row_addr_t;

	// ----------------------------------------
	// burst word counter
	// ----------------------------------------
	typedef logic [`FB_BL_WIDTH-1:0] word_cnt_t;

	// counter idles at all ones so the first read wraps it to zero
	localparam word_cnt_t WORD_CNT_INIT = '1;
	// value before the read that completes a full burst
	localparam word_cnt_t WORD_CNT_LAST = word_cnt_t'(`FB_BURST_WORDS - 2);

endpackage

/* src/mcb_pkg.sv */
// memory controller port types: data word, burst length, byte address
`include "frame_buf_cfg.svh"

package mcb_pkg;

	// ----------------------------------------
	// write data FIFO side
	// ----------------------------------------
	// one word pushed into the port write FIFO
	typedef logic [`FB_DATA_WIDTH-1:0] mcb_data_t;

	// ----------------------------------------
	// command FIFO side
	// ----------------------------------------
	// words in the command minus one
	typedef logic [`FB_BL_WIDTH-1:0] mcb_bl_t;

	// start byte address of the command
	typedef logic [`FB_BYTE_ADDR_WIDTH-1:0] mcb_byte_addr_t;

endpackage

/* src/frame_sync.sv */
// frame-valid and calibration synchronisers, frame-valid edge detect, frame armed flag
`timescale 1ns/1ps

module frame_sync (
	input	logic	clk,
	input	logic	reset,
	// asynchronous frame valid, high during a frame
	input	logic	i_fval,
	// calibration done from the controller clock domain
	input	logic	i_calib_done,
	// write enable from the sequencer
	input	logic	i_enable,
	output	logic	o_fval_level,
	output	logic	o_frame_armed,
	output	logic	o_calib_done
);

	logic	[2:0]	fval_shift;
	logic	[1:0]	calib_shift;
	logic			fval_rise;
	logic			fval_fall;
	logic			armed;

	// ----------------------------------------
	// synchronisers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fval_shift	<= 3'b000;
			calib_shift	<= 2'b00;
		end else begin
			fval_shift	<= {fval_shift[1:0], i_fval};
			calib_shift	<= {calib_shift[0], i_calib_done};
		end
	end

	// edges taken from the two settled stages
	assign fval_rise = (fval_shift[2:1] == 2'b01);
	assign fval_fall = (fval_shift[2:1] == 2'b10);

	// ----------------------------------------
	// armed flag
	// ----------------------------------------
	// remembers that a frame began while enabled
	// a frame already running at enable time never arms
	always_ff @(posedge clk) begin
		if (reset || !i_enable) begin
			armed <= 1'b0;
		end else if (fval_rise) begin
			armed <= 1'b1;
		end else if (fval_fall) begin
			armed <= 1'b0;
		end
	end

	// second stage is the level used by the sequencer
	assign o_fval_level		= fval_shift[1];
	assign o_frame_armed	= armed;
	assign o_calib_done		= calib_shift[1];

endmodule

/* src/wr_burst_fsm.sv */
// write sequencer: enable and depth latches, state machine, word counter, strobes, row counter
`timescale 1ns/1ps

module wr_burst_fsm (
	input	logic							clk,
	input	logic							reset,
	// from frame_sync
	input	logic							i_fval_level,
	input	logic							i_frame_armed,
	input	logic							i_calib_done,
	// control switches
	input	logic							i_start_full_frame,
	input	logic							i_start_quick,
	input	frame_buf_pkg::frame_depth_t	iv_frame_depth,
	// front FIFO flags
	input	logic							i_buf_pe,
	input	logic							i_buf_empty,
	// arbiter and read side
	input	logic							i_wr_ack,
	input	logic							i_reading,
	// memory controller flags
	input	logic							i_p2_wr_full,
	input	logic							i_p2_cmd_full,
	output	logic							o_buf_rd_en,
	output	logic							o_p2_wr_en,
	output	logic							o_p2_cmd_en,
	output	mcb_pkg::mcb_bl_t				ov_p2_cmd_bl,
	output	logic							o_wr_req,
	output	logic							o_writing,
	output	logic							o_enable,
	output	frame_buf_pkg::frame_depth_t	ov_frame_depth,
	output	frame_buf_pkg::row_addr_t		ov_row_addr
);

	frame_buf_pkg::wr_state_t		state_q;
	frame_buf_pkg::wr_state_t		state_d;
	frame_buf_pkg::frame_depth_t	depth_q;
	frame_buf_pkg::word_cnt_t		word_cnt;
	frame_buf_pkg::row_addr_t		row_addr;
	logic							full_frame_q;
	logic							enable;
	logic							able_to_write;
	logic							buf_rd;
	logic							frame_end;
	logic							wr_req_q;
	logic							writing_q;
	logic							cmd_en_q;

	// ----------------------------------------
	// enable and depth, sampled in idle only
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			full_frame_q	<= 1'b0;
			depth_q			<= '0;
		end else if (state_q == frame_buf_pkg::S_IDLE) begin
			full_frame_q	<= i_start_full_frame;
			depth_q			<= iv_frame_depth;
		end
	end

	// quick stop acts at once, full frame waits for idle
	assign enable = full_frame_q & i_start_quick;

	// single frame: no write while that frame is being read
	assign able_to_write = (depth_q == '0) ? !i_reading : 1'b1;

	// frame over and front FIFO drained
	assign frame_end = !i_fval_level && i_buf_empty;

	// read and write strobes share one source, FWFT data is already valid
	assign buf_rd = (state_q == frame_buf_pkg::S_WR) && !i_buf_empty && !i_p2_wr_full;

	// ----------------------------------------
	// state machine
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= frame_buf_pkg::S_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			frame_buf_pkg::S_IDLE: begin
				if (i_frame_armed && i_buf_pe && enable && i_calib_done && able_to_write) begin
					state_d = frame_buf_pkg::S_REQ;
				end
			end
			frame_buf_pkg::S_REQ: begin
				// ack without permission drops back to idle
				if (!enable) begin
					state_d = frame_buf_pkg::S_IDLE;
				end else if (i_wr_ack) begin
					state_d = able_to_write ? frame_buf_pkg::S_WR : frame_buf_pkg::S_IDLE;
				end
			end
			frame_buf_pkg::S_WR: begin
				if (!enable) begin
					state_d = frame_buf_pkg::S_CMD;
				end else if (word_cnt == frame_buf_pkg::WORD_CNT_LAST) begin
					// 64th word read, or 63 words left at frame end
					if (buf_rd || frame_end) begin
						state_d = frame_buf_pkg::S_CMD;
					end
				end else if (word_cnt == frame_buf_pkg::WORD_CNT_INIT) begin
					// nothing pending
					if (frame_end) begin
						state_d = frame_buf_pkg::S_IDLE;
					end
				end else if (frame_end) begin
					// partial burst closes the frame
					state_d = frame_buf_pkg::S_CMD;
				end
			end
			frame_buf_pkg::S_CMD: begin
				if (!enable) begin
					state_d = frame_buf_pkg::S_IDLE;
				end else if (!i_p2_cmd_full) begin
					state_d = frame_end ? frame_buf_pkg::S_IDLE : frame_buf_pkg::S_WR;
				end
			end
			default: state_d = frame_buf_pkg::S_IDLE;
		endcase
	end

	// ----------------------------------------
	// strobes towards arbiter and command FIFO
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_req_q	<= 1'b0;
			cmd_en_q	<= 1'b0;
			writing_q	<= 1'b0;
		end else begin
			wr_req_q	<= (state_q == frame_buf_pkg::S_REQ) && !i_wr_ack;
			cmd_en_q	<= (state_q == frame_buf_pkg::S_CMD) && !i_p2_cmd_full;
			if (state_q == frame_buf_pkg::S_IDLE) begin
				writing_q <= 1'b0;
			end else if (i_wr_ack && able_to_write) begin
				writing_q <= 1'b1;
			end
		end
	end

	// burst word counter, wraps modulo 64
	always_ff @(posedge clk) begin
		if (reset || state_q == frame_buf_pkg::S_IDLE) begin
			word_cnt <= frame_buf_pkg::WORD_CNT_INIT;
		end else if (buf_rd) begin
			word_cnt <= word_cnt + 1'b1;
		end
	end

	// row steps after each command, so the command carries the old row
	always_ff @(posedge clk) begin
		if (reset || state_q == frame_buf_pkg::S_IDLE) begin
			row_addr <= '0;
		end else if (cmd_en_q) begin
			row_addr <= row_addr + 1'b1;
		end
	end

	assign o_buf_rd_en		= buf_rd;
	assign o_p2_wr_en		= buf_rd;
	assign o_p2_cmd_en		= cmd_en_q;
	assign ov_p2_cmd_bl		= word_cnt;
	assign o_wr_req			= wr_req_q;
	assign o_writing		= writing_q;
	assign o_enable			= enable;
	assign ov_frame_depth	= depth_q;
	assign ov_row_addr		= row_addr;

endmodule

/* src/wr_frame_ptr.sv */
// write frame pointer: advance per acknowledge, skip over the frame being read
`timescale 1ns/1ps
`include "frame_buf_cfg.svh"

module wr_frame_ptr (
	input	logic							clk,
	input	logic							reset,
	input	logic							i_enable,
	input	frame_buf_pkg::frame_depth_t	iv_frame_depth,
	// one pulse per granted request
	input	logic							i_wr_ack,
	input	logic							i_reading,
	input	frame_buf_pkg::frame_ptr_t		iv_rd_frame_ptr,
	output	frame_buf_pkg::frame_ptr_t		ov_wr_frame_ptr
);

	frame_buf_pkg::frame_ptr_t	wr_ptr;
	frame_buf_pkg::frame_ptr_t	step_one;
	frame_buf_pkg::frame_ptr_t	step_two;
	frame_buf_pkg::frame_ptr_t	next_ptr;

	// next frame modulo depth plus one
	// at or past the top wraps to frame 0
	function automatic frame_buf_pkg::frame_ptr_t step_ptr(
		input frame_buf_pkg::frame_ptr_t	ptr,
		input frame_buf_pkg::frame_depth_t	depth
	);
		frame_buf_pkg::frame_ptr_t result;
		if (ptr >= depth) begin
			result = '0;
		end else begin
			result = ptr + 1'b1;
		end
		return result;
	endfunction

	// ----------------------------------------
	// candidate pointers
	// ----------------------------------------
	assign step_one = step_ptr(wr_ptr, iv_frame_depth);
	assign step_two = step_ptr(step_one, iv_frame_depth);

	// jump one more when the plain step lands on the read frame
	assign next_ptr = (i_reading && step_one == iv_rd_frame_ptr) ? step_two : step_one;

	// ----------------------------------------
	// pointer register
	// ----------------------------------------
	// single frame or disabled parks the pointer at its start value
	always_ff @(posedge clk) begin
		if (reset || !i_enable || iv_frame_depth == '0) begin
			wr_ptr <= frame_buf_pkg::frame_ptr_t'(`FB_PTR_RESET);
		end else if (i_wr_ack) begin
			wr_ptr <= next_ptr;
		end
	end

	assign ov_wr_frame_ptr = wr_ptr;

endmodule

/* src/ddr_addr_map.sv */
// command byte address mapping by frame depth class, 1 Gb part
`timescale 1ns/1ps
`include "frame_buf_cfg.svh"

module ddr_addr_map (
	input	frame_buf_pkg::frame_depth_t	iv_frame_depth,
	input	frame_buf_pkg::frame_ptr_t		iv_wr_frame_ptr,
	input	frame_buf_pkg::row_addr_t		iv_row_addr,
	output	mcb_pkg::mcb_byte_addr_t		ov_p2_cmd_byte_addr
);

	// zero bits above the row field
	localparam int TOP_ZEROS = `FB_BYTE_ADDR_WIDTH - `FB_ROW_WIDTH - `FB_BYTE_LSB;

	// frame and row share one field, the frame takes the top bits
	frame_buf_pkg::row_addr_t	field;

	// ----------------------------------------
	// depth classes
	// ----------------------------------------
	always_comb begin
		case (iv_frame_depth)
			// single frame owns the whole row range
			2'd0: field = iv_row_addr;
			// two frames
			2'd1: field = {iv_wr_frame_ptr[0], iv_row_addr[`FB_ROW_WIDTH-2:0]};
			// three or four frames
			default: field = {iv_wr_frame_ptr[1:0], iv_row_addr[`FB_ROW_WIDTH-3:0]};
		endcase
	end

	// 256-byte bursts, low bits fixed at zero
	assign ov_p2_cmd_byte_addr = {{TOP_ZEROS{1'b0}}, field, {`FB_BYTE_LSB{1'b0}}};

endmodule

/* src/wr_logic.sv */
// frame buffer write side top: synchronise, sequence, point, map
`timescale 1ns/1ps

module wr_logic (
	input	logic							clk,
	input	logic							reset,
	// image side, asynchronous
	input	logic							i_fval,
	// controller calibration
	input	logic							i_calib_done,
	// control
	input	frame_buf_pkg::frame_depth_t	iv_frame_depth,
	input	logic							i_start_full_frame,
	input	logic							i_start_quick,
	// front FIFO, first word fall through
	input	mcb_pkg::mcb_data_t				iv_buf_dout,
	output	logic							o_buf_rd_en,
	input	logic							i_buf_pe,
	input	logic							i_buf_empty,
	// write status
	output	frame_buf_pkg::frame_ptr_t		ov_wr_frame_ptr,
	output	frame_buf_pkg::row_addr_t		ov_wr_addr,
	output	logic							o_writing,
	// arbiter
	output	logic							o_wr_req,
	input	logic							i_wr_ack,
	// read side
	input	frame_buf_pkg::frame_ptr_t		iv_rd_frame_ptr,
	input	logic							i_reading,
	// controller command FIFO
	output	logic							o_p2_cmd_en,
	output	mcb_pkg::mcb_bl_t				ov_p2_cmd_bl,
	output	mcb_pkg::mcb_byte_addr_t		ov_p2_cmd_byte_addr,
	input	logic							i_p2_cmd_full,
	// controller write FIFO
	output	logic							o_p2_wr_en,
	output	mcb_pkg::mcb_data_t				ov_p2_wr_data,
	input	logic							i_p2_wr_full
);

	logic							fval_level;
	logic							frame_armed;
	logic							calib_done;
	logic							enable;
	frame_buf_pkg::frame_depth_t	frame_depth;

	// ----------------------------------------
	// synchronise
	// ----------------------------------------
	frame_sync sync_i (
		.clk			(clk),
		.reset			(reset),
		.i_fval			(i_fval),
		.i_calib_done	(i_calib_done),
		.i_enable		(enable),
		.o_fval_level	(fval_level),
		.o_frame_armed	(frame_armed),
		.o_calib_done	(calib_done)
	);

	// ----------------------------------------
	// sequence
	// ----------------------------------------
	wr_burst_fsm fsm_i (
		.clk				(clk),
		.reset				(reset),
		.i_fval_level		(fval_level),
		.i_frame_armed		(frame_armed),
		.i_calib_done		(calib_done),
		.i_start_full_frame	(i_start_full_frame),
		.i_start_quick		(i_start_quick),
		.iv_frame_depth		(iv_frame_depth),
		.i_buf_pe			(i_buf_pe),
		.i_buf_empty		(i_buf_empty),
		.i_wr_ack			(i_wr_ack),
		.i_reading			(i_reading),
		.i_p2_wr_full		(i_p2_wr_full),
		.i_p2_cmd_full		(i_p2_cmd_full),
		.o_buf_rd_en		(o_buf_rd_en),
		.o_p2_wr_en			(o_p2_wr_en),
		.o_p2_cmd_en		(o_p2_cmd_en),
		.ov_p2_cmd_bl		(ov_p2_cmd_bl),
		.o_wr_req			(o_wr_req),
		.o_writing			(o_writing),
		.o_enable			(enable),
		.ov_frame_depth		(frame_depth),
		.ov_row_addr		(ov_wr_addr)
	);

	// point and map, both work on the latched depth
	wr_frame_ptr ptr_i (
		.clk				(clk),
		.reset				(reset),
		.i_enable			(enable),
		.iv_frame_depth		(frame_depth),
		.i_wr_ack			(i_wr_ack),
		.i_reading			(i_reading),
		.iv_rd_frame_ptr	(iv_rd_frame_ptr),
		.ov_wr_frame_ptr	(ov_wr_frame_ptr)
	);

	ddr_addr_map map_i (
		.iv_frame_depth			(frame_depth),
		.iv_wr_frame_ptr		(ov_wr_frame_ptr),
		.iv_row_addr			(ov_wr_addr),
		.ov_p2_cmd_byte_addr	(ov_p2_cmd_byte_addr)
	);

	// FWFT output goes straight into the controller write FIFO
	assign ov_p2_wr_data = iv_buf_dout;

endmodule

/* tb/tb_wr_logic.sv */
// wr_logic testbench with clock, front FIFO and arbiter models, back-pressure and reference checks
`timescale 1ns/1ps
`include "frame_buf_cfg.svh"

module tb_wr_logic;

	localparam int NUM_FRAMES = 12;

	logic							clk;
	logic							reset;
	logic							i_fval;
	logic							i_calib_done;
	frame_buf_pkg::frame_depth_t	iv_frame_depth;
	logic							i_start_full_frame;
	logic							i_start_quick;
	mcb_pkg::mcb_data_t				iv_buf_dout;
	logic							o_buf_rd_en;
	logic							i_buf_pe;
	logic							i_buf_empty;
	frame_buf_pkg::frame_ptr_t		ov_wr_frame_ptr;
	frame_buf_pkg::row_addr_t		ov_wr_addr;
	logic							o_writing;
	logic							o_wr_req;
	logic							i_wr_ack;
	frame_buf_pkg::frame_ptr_t		iv_rd_frame_ptr;
	logic							i_reading;
	logic							o_p2_cmd_en;
	mcb_pkg::mcb_bl_t				ov_p2_cmd_bl;
	mcb_pkg::mcb_byte_addr_t		ov_p2_cmd_byte_addr;
	logic							i_p2_cmd_full;
	logic							o_p2_wr_en;
	mcb_pkg::mcb_data_t				ov_p2_wr_data;
	logic							i_p2_wr_full;

	integer				seed = 32'h633d39cd;
	int					errors;
	// frame plan drawn once before reset
	int					frame_len [NUM_FRAMES];
	logic	[1:0]		frame_depth [NUM_FRAMES];
	logic				frame_reading [NUM_FRAMES];
	logic	[1:0]		frame_rd_ptr [NUM_FRAMES];
	logic				frame_hold [NUM_FRAMES];
	int					total_words;
	logic				plan_ready;
	// front FIFO model and its feeder
	mcb_pkg::mcb_data_t	fifo_q [$];
	mcb_pkg::mcb_data_t	exp_word;
	int					push_left;
	int					ack_wait;
	// scoreboard state
	int					burst_words;
	int					frame_words;
	int					cmd_idx;
	int					words_written;
	int					cmds_seen;
	logic				partial_seen;
	logic	[1:0]		model_ptr;
	logic				ptr_check;
	logic				ack_reading;
	logic	[1:0]		ack_depth;
	logic	[1:0]		ack_rd_ptr;
	logic				quiet_check;
	logic				hold_check;

	wr_logic dut_i (
		.clk					(clk),
		.reset					(reset),
		.i_fval					(i_fval),
		.i_calib_done			(i_calib_done),
		.iv_frame_depth			(iv_frame_depth),
		.i_start_full_frame		(i_start_full_frame),
		.i_start_quick			(i_start_quick),
		.iv_buf_dout			(iv_buf_dout),
		.o_buf_rd_en			(o_buf_rd_en),
		.i_buf_pe				(i_buf_pe),
		.i_buf_empty			(i_buf_empty),
		.ov_wr_frame_ptr		(ov_wr_frame_ptr),
		.ov_wr_addr				(ov_wr_addr),
		.o_writing				(o_writing),
		.o_wr_req				(o_wr_req),
		.i_wr_ack				(i_wr_ack),
		.iv_rd_frame_ptr		(iv_rd_frame_ptr),
		.i_reading				(i_reading),
		.o_p2_cmd_en			(o_p2_cmd_en),
		.ov_p2_cmd_bl			(ov_p2_cmd_bl),
		.ov_p2_cmd_byte_addr	(ov_p2_cmd_byte_addr),
		.i_p2_cmd_full			(i_p2_cmd_full),
		.o_p2_wr_en				(o_p2_wr_en),
		.ov_p2_wr_data			(ov_p2_wr_data),
		.i_p2_wr_full			(i_p2_wr_full)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ----------------------------------------
	// reporting and reference helpers
	// ----------------------------------------
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED: %s is %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("error at %0t: %s", $time, msg);
	endtask

	task automatic check_controls_low();
		compare_value("o_wr_req", o_wr_req, 0);
		compare_value("o_writing", o_writing, 0);
		compare_value("o_p2_cmd_en", o_p2_cmd_en, 0);
		compare_value("o_buf_rd_en", o_buf_rd_en, 0);
		compare_value("o_p2_wr_en", o_p2_wr_en, 0);
	endtask

	// one step through frames 0 to depth wrapping past the top
	function automatic logic [1:0] wrap_step(input int ptr, input int depth);
		int nxt;
		nxt = ptr + 1;
		if (nxt > depth) begin
			nxt = 0;
		end
		return nxt[1:0];
	endfunction

	// next write frame stepping over the frame under read
	function automatic logic [1:0] advance_ptr(input logic [1:0] ptr, input logic [1:0] depth,
		input logic reading, input logic [1:0] rd_ptr);
		logic [1:0] nxt;
		nxt = wrap_step(ptr, depth);
		if (reading && nxt == rd_ptr) begin
			nxt = wrap_step(nxt, depth);
		end
		return nxt;
	endfunction

	// row in bits 8 up and frame bits at the top of the 19 bit field
	function automatic logic [31:0] expected_addr(input logic [1:0] depth,
		input logic [1:0] ptr, input int row);
		logic [31:0] addr;
		addr = 32'(row) << 8;
		if (depth == 2'd1) begin
			addr = addr | (32'(ptr[0]) << 26);
		end else if (depth != 2'd0) begin
			addr = addr | (32'(ptr) << 25);
		end
		return addr;
	endfunction

	// ----------------------------------------
	// front FIFO, arbiter, back-pressure
	// ----------------------------------------
	initial begin
		i_buf_empty = 1'b1;
		i_buf_pe = 1'b0;
		iv_buf_dout = '0;
		i_p2_wr_full = 1'b0;
		i_p2_cmd_full = 1'b0;
		i_wr_ack = 1'b0;
		ack_wait = 0;
		forever begin
			@(negedge clk);
			// roughly three pushes in four cycles
			if (push_left > 0 && ($random(seed) & 3) != 0) begin
				fifo_q.push_back($random(seed));
				push_left = push_left - 1;
			end
			i_buf_empty = (fifo_q.size() == 0);
			iv_buf_dout = (fifo_q.size() != 0) ? fifo_q[0] : '0;
			// pe also covers the tail of a frame shorter than a burst
			i_buf_pe = (fifo_q.size() >= `FB_BURST_WORDS) ||
				(push_left == 0 && fifo_q.size() != 0);
			i_p2_wr_full = (($random(seed) & 7) == 0);
			i_p2_cmd_full = (($random(seed) & 3) == 0);
			// grant 1 to 5 cycles after the request
			if (i_wr_ack) begin
				i_wr_ack = 1'b0;
			end else if (ack_wait > 0) begin
				ack_wait = ack_wait - 1;
				if (ack_wait == 0) begin
					i_wr_ack = 1'b1;
				end
			end else if (o_wr_req) begin
				ack_wait = 1 + ($unsigned($random(seed)) % 5);
			end
		end
	end

	// ----------------------------------------
	// monitor and scoreboard
	// ----------------------------------------
	always @(posedge clk) begin
		if (ptr_check) begin
			compare_value("ov_wr_frame_ptr", ov_wr_frame_ptr, model_ptr);
			if (ack_reading && ack_depth != 2'd0 && ov_wr_frame_ptr == ack_rd_ptr) begin
				report_error("write pointer moved onto the frame being read");
			end
			ptr_check = 1'b0;
		end
		if (!reset) begin
			compare_value("o_buf_rd_en vs o_p2_wr_en", o_buf_rd_en, o_p2_wr_en);
			if (quiet_check && (o_wr_req || o_buf_rd_en || o_p2_cmd_en || o_writing)) begin
				report_error("write activity while disabled or before calibration");
			end
			if (hold_check && (o_wr_req || o_buf_rd_en)) begin
				report_error("single-frame write started while a read runs");
			end
			// command first since it closes the words counted so far
			if (o_p2_cmd_en) begin
				cmds_seen++;
				compare_value("ov_p2_cmd_bl + 1", 32'(ov_p2_cmd_bl) + 32'd1, burst_words);
				compare_value("ov_wr_addr", ov_wr_addr, cmd_idx);
				compare_value("ov_p2_cmd_byte_addr", ov_p2_cmd_byte_addr,
					expected_addr(iv_frame_depth, model_ptr, cmd_idx));
				if (partial_seen) begin
					report_error("command after a short burst in the same frame");
				end
				if (burst_words != `FB_BURST_WORDS) begin
					partial_seen = 1'b1;
				end
				frame_words = frame_words + burst_words;
				cmd_idx++;
				burst_words = 0;
			end
			if (o_buf_rd_en) begin
				if (fifo_q.size() == 0) begin
					report_error("front FIFO read while empty");
				end else if (i_p2_wr_full) begin
					report_error("write FIFO written while full");
				end else begin
					exp_word = fifo_q.pop_front();
					compare_value("ov_p2_wr_data", ov_p2_wr_data, exp_word);
					burst_words++;
					words_written++;
				end
			end
		end
		if (i_wr_ack) begin
			ptr_check = 1'b1;
			ack_reading = i_reading;
			ack_depth = iv_frame_depth;
			ack_rd_ptr = iv_rd_frame_ptr;
		end
		if (reset || !(i_start_full_frame && i_start_quick) || iv_frame_depth == 2'd0) begin
			model_ptr = `FB_PTR_RESET;
		end else if (i_wr_ack) begin
			model_ptr = advance_ptr(model_ptr, iv_frame_depth, i_reading, iv_rd_frame_ptr);
		end
	end

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		wait (plan_ready);
		repeat (total_words * 40 + 5000) @(posedge clk);
		$display("timeout: %0d of %0d words written", words_written, total_words);
		$display("TESTS FAILED");
		$finish;
	end

	// 80 words pushed with one of quick stop or calibration off
	task automatic run_quiet_phase(input logic quick, input logic calib);
		@(negedge clk);
		i_start_full_frame = 1'b1;
		i_start_quick = quick;
		i_calib_done = calib;
		quiet_check = 1'b1;
		repeat (5) @(negedge clk);
		i_fval = 1'b1;
		@(posedge clk);
		push_left = 80;
		while (push_left != 0) @(negedge clk);
		repeat (100) @(negedge clk);
		i_fval = 1'b0;
		repeat (10) @(negedge clk);
		compare_value("ov_wr_frame_ptr", ov_wr_frame_ptr, `FB_PTR_RESET);
		quiet_check = 1'b0;
		@(posedge clk);
		fifo_q.delete();
	endtask

	task automatic run_frame(input int idx);
		@(negedge clk);
		iv_frame_depth = frame_depth[idx];
		iv_rd_frame_ptr = frame_rd_ptr[idx];
		i_reading = frame_hold[idx] ? 1'b1 : frame_reading[idx];
		frame_words = 0;
		cmd_idx = 0;
		burst_words = 0;
		partial_seen = 1'b0;
		repeat (4) @(negedge clk);
		i_fval = 1'b1;
		@(posedge clk);
		push_left = frame_len[idx];
		if (frame_hold[idx]) begin
			hold_check = 1'b1;
			while (push_left != 0) @(negedge clk);
			repeat (30) @(negedge clk);
			hold_check = 1'b0;
			i_reading = 1'b0;
		end
		// frame valid stays up until the grant and the last push
		while (!o_writing || push_left != 0) @(negedge clk);
		i_fval = 1'b0;
		while (frame_words < frame_len[idx]) @(negedge clk);
		while (o_writing) @(negedge clk);
		compare_value("frame words", frame_words, frame_len[idx]);
		if (fifo_q.size() != 0) begin
			report_error("words left in the front FIFO after the frame");
		end
	endtask

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial begin
		errors = 0;
		reset = 1'b1;
		i_fval = 1'b0;
		i_calib_done = 1'b0;
		iv_frame_depth = '0;
		i_start_full_frame = 1'b0;
		i_start_quick = 1'b0;
		iv_rd_frame_ptr = '0;
		i_reading = 1'b0;
		push_left = 0;
		words_written = 0;
		cmds_seen = 0;
		burst_words = 0;
		frame_words = 0;
		cmd_idx = 0;
		partial_seen = 1'b0;
		model_ptr = `FB_PTR_RESET;
		ptr_check = 1'b0;
		quiet_check = 1'b0;
		hold_check = 1'b0;
		total_words = 0;
		for (int i = 0; i < NUM_FRAMES; i++) begin
			frame_len[i] = 20 + ($unsigned($random(seed)) % 281);
			frame_depth[i] = $random(seed) & 3;
			frame_rd_ptr[i] = $unsigned($random(seed)) % (frame_depth[i] + 1);
			frame_reading[i] = (frame_depth[i] != 0) && ($random(seed) & 1);
			frame_hold[i] = (frame_depth[i] == 0) && ($random(seed) & 1);
			total_words = total_words + frame_len[i];
		end
		plan_ready = 1'b1;

		repeat (3) begin
			@(negedge clk);
			check_controls_low();
		end
		reset = 1'b0;
		@(negedge clk);
		check_controls_low();
		compare_value("ov_wr_frame_ptr", ov_wr_frame_ptr, `FB_PTR_RESET);

		run_quiet_phase(1'b0, 1'b1);
		run_quiet_phase(1'b1, 1'b0);
		@(negedge clk);
		i_calib_done = 1'b1;
		repeat (5) @(negedge clk);
		for (int i = 0; i < NUM_FRAMES; i++) begin
			run_frame(i);
		end
		// quick stop after the frames parks a moved pointer
		run_quiet_phase(1'b0, 1'b1);
		repeat (10) @(negedge clk);

		$display("errors %0d, words %0d of %0d, commands %0d, frames %0d",
			errors, words_written, total_words, cmds_seen, NUM_FRAMES);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
+incdir+src
src/frame_buf_pkg.sv
src/mcb_pkg.sv
src/frame_sync.sv
src/wr_burst_fsm.sv
src/wr_frame_ptr.sv
src/ddr_addr_map.sv
src/wr_logic.sv
tb/tb_wr_logic.sv

/* Bender.yml */
package:
  name: frame_buf_wr

export_include_dirs:
  - src

sources:
  - files:
      - src/frame_buf_pkg.sv
      - src/mcb_pkg.sv
      - src/frame_sync.sv
      - src/wr_burst_fsm.sv
      - src/wr_frame_ptr.sv
      - src/ddr_addr_map.sv
      - src/wr_logic.sv
  - target: simulation
    files:
      - tb/tb_wr_logic.sv
